/* rtl/vadd_pkg.sv */
/*
 * Shared widths, opcode and element width enums,
 * control, operand and result structs for the vector add unit
 */
package vadd_pkg;

    // Vector word geometry
    localparam int VADD_NUM_BYTES  = 8;
    localparam int VADD_DATA_WIDTH = VADD_NUM_BYTES * 8;
    // SEW8, SEW16, SEW32, SEW64
    localparam int VADD_NUM_SIZES  = 4;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        ADC,
        MIN,
        MINU,
        MAX,
        MAXU,
        SEQ,
        SNE,
        SLT,
        SLTU,
        SGT,
        SGTU
    } vadd_op_e;

    typedef enum logic [1:0] {
        SEW8,
        SEW16,
        SEW32,
        SEW64
    } vadd_sew_e;

    // Adder strobes from the decoder
    typedef struct packed {
        logic                      is_add;
        logic                      is_sub;
        logic                      use_carry;
        logic                      is_arithmetic;
        logic                      is_min_max;
        logic                      is_max;
        logic                      is_signed;
        logic                      is_set_equal;
        logic                      is_set_nequal;
        logic                      is_set_less;
        logic                      is_set_greater;
        logic [VADD_NUM_SIZES-1:0] osize_vector;
        // Carry of byte i propagates into byte i+1
        logic [VADD_NUM_BYTES-1:0] merge;
    } vadd_ctrl_t;

    typedef struct packed {
        logic [VADD_DATA_WIDTH-1:0] data;
        logic [VADD_NUM_BYTES-1:0]  valid;
    } vadd_operand_t;

    // Flags are per byte
    typedef struct packed {
        logic [VADD_DATA_WIDTH-1:0] data;
        logic [VADD_NUM_BYTES-1:0]  zf;
        logic [VADD_NUM_BYTES-1:0]  of;
        logic [VADD_NUM_BYTES-1:0]  cf;
    } vadd_result_t;

endpackage

/* rtl/vadd_decode.sv */
/*
 * Opcode and element width decoder,
 * drives the adder control strobes, size one-hot and byte merge map
 */
`timescale 1ns/1ps

module vadd_decode (
    input  vadd_pkg::vadd_op_e   op,
    input  vadd_pkg::vadd_sew_e  sew,
    output vadd_pkg::vadd_ctrl_t ctrl
);

    localparam int NUM_BYTES = vadd_pkg::VADD_NUM_BYTES;

    int elem_bytes;

    always_comb begin
        ctrl       = '0;
        elem_bytes = 1 << sew;

        case (op)
            vadd_pkg::ADD: begin
                ctrl.is_add        = 1'b1;
                ctrl.is_arithmetic = 1'b1;
            end
            vadd_pkg::SUB: begin
                ctrl.is_sub        = 1'b1;
                ctrl.is_arithmetic = 1'b1;
            end
            vadd_pkg::ADC: begin
                ctrl.is_add        = 1'b1;
                ctrl.use_carry     = 1'b1;
                ctrl.is_arithmetic = 1'b1;
            end
            // Min/max and compares all subtract srcb from srca
            vadd_pkg::MIN, vadd_pkg::MINU: begin
                ctrl.is_sub     = 1'b1;
                ctrl.is_min_max = 1'b1;
            end
            vadd_pkg::MAX, vadd_pkg::MAXU: begin
                ctrl.is_sub     = 1'b1;
                ctrl.is_min_max = 1'b1;
                ctrl.is_max     = 1'b1;
            end
            vadd_pkg::SEQ: begin
                ctrl.is_sub       = 1'b1;
                ctrl.is_set_equal = 1'b1;
            end
            vadd_pkg::SNE: begin
                ctrl.is_sub        = 1'b1;
                ctrl.is_set_nequal = 1'b1;
            end
            vadd_pkg::SLT, vadd_pkg::SLTU: begin
                ctrl.is_sub      = 1'b1;
                ctrl.is_set_less = 1'b1;
            end
            vadd_pkg::SGT, vadd_pkg::SGTU: begin
                ctrl.is_sub         = 1'b1;
                ctrl.is_set_greater = 1'b1;
            end
            default: begin
                ctrl.is_arithmetic = 1'b0;
            end
        endcase

        ctrl.is_signed = (op == vadd_pkg::MIN) || (op == vadd_pkg::MAX) ||
                         (op == vadd_pkg::SLT) || (op == vadd_pkg::SGT);

        ctrl.osize_vector = '0;
        ctrl.osize_vector[sew] = 1'b1;

        // No merge out of the top byte of an element
        for (int b = 0; b < NUM_BYTES; b++) begin
            ctrl.merge[b] = (((b + 1) & (elem_bytes - 1)) != 0);
        end
    end

endmodule

/* rtl/vadd_issue_reg.sv */
/*
 * Issue register between decoder and datapath
 */
`timescale 1ns/1ps

module vadd_issue_reg (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                in_valid,
    input  vadd_pkg::vadd_ctrl_t                ctrl_in,
    input  vadd_pkg::vadd_operand_t             srca_in,
    input  vadd_pkg::vadd_operand_t             srcb_in,
    input  logic [vadd_pkg::VADD_NUM_BYTES-1:0] carry_in,
    output logic                                iss_valid,
    output vadd_pkg::vadd_ctrl_t                ctrl,
    output vadd_pkg::vadd_operand_t             srca,
    output vadd_pkg::vadd_operand_t             srcb,
    output logic [vadd_pkg::VADD_NUM_BYTES-1:0] carry
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid <= 1'b0;
            ctrl      <= '0;
            srca      <= '0;
            srcb      <= '0;
            carry     <= '0;
        end else begin
            iss_valid <= in_valid;
            ctrl      <= ctrl_in;
            srca      <= srca_in;
            srcb      <= srcb_in;
            carry     <= carry_in;
        end
    end

endmodule

/* rtl/vadd_byte_adder.sv */
/*
 * 8-bit ripple carry adder slice with carry into the sign bit
 */
`timescale 1ns/1ps

module vadd_byte_adder (
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic       cin,
    output logic [7:0] sum,
    output logic       prev_cout,
    output logic       cout
);

    logic [8:0] c;

    always_comb begin
        c[0] = cin;
        for (int i = 0; i < 8; i++) begin
            sum[i]   = a[i] ^ b[i] ^ c[i];
            c[i + 1] = (a[i] & b[i]) | (c[i] & (a[i] ^ b[i]));
        end
    end

    // Carry into bit 7 for signed overflow
    assign prev_cout = c[7];
    assign cout      = c[8];

endmodule

/* rtl/vadd_alu.sv */
/*
 * Byte-sliced add/compare datapath
 * merged carry chain, flags, min/max select, compare masks
 */
`timescale 1ns/1ps

module vadd_alu (
    input  logic                                valid,
    input  vadd_pkg::vadd_ctrl_t                ctrl,
    input  vadd_pkg::vadd_operand_t             srca,
    input  vadd_pkg::vadd_operand_t             srcb,
    input  logic [vadd_pkg::VADD_NUM_BYTES-1:0] carry,
    output vadd_pkg::vadd_result_t              res
);

    localparam int NB = vadd_pkg::VADD_NUM_BYTES;
    localparam int DW = vadd_pkg::VADD_DATA_WIDTH;
    localparam int BW = DW / NB;
    localparam int NS = vadd_pkg::VADD_NUM_SIZES;

    logic [NB-1:0] active;
    logic [DW-1:0] srca_gated;
    logic [DW-1:0] srcb_gated;
    logic [DW-1:0] srcb_adder;
    logic [DW-1:0] sum;
    logic [DW-1:0] arith_qual;
    logic [NB-1:0] cin;
    logic [NB-1:0] prev_cout;
    logic [NB-1:0] cout;
    logic [NB-1:0] zf_byte;
    logic [NB-1:0] signed_of;
    logic [NB-1:0] unsigned_of;
    logic [NB-1:0] less_byte;

    logic [DW-1:0] min_max_size [NS];
    logic [NB-1:0] zf_size      [NS];
    logic [NB-1:0] eq_size      [NS];
    logic [NB-1:0] ne_size      [NS];
    logic [NB-1:0] lt_size      [NS];
    logic [NB-1:0] gt_size      [NS];

    logic [DW-1:0] min_max_qual;
    logic [NB-1:0] zf_all;
    logic [NB-1:0] eq_mask;
    logic [NB-1:0] ne_mask;
    logic [NB-1:0] lt_mask;
    logic [NB-1:0] gt_mask;
    logic [NB-1:0] cmp_mask;

    assign active     = srca.valid & srcb.valid;
    assign srca_gated = srca.data & {DW{valid}};
    assign srcb_gated = srcb.data & {DW{valid}};

    generate
        for (genvar b = 0; b < NB; b++) begin : gen_byte
            // Inactive srcb bytes add nothing
            assign srcb_adder[b*BW +: BW] = (srcb_gated[b*BW +: BW] ^ {BW{ctrl.is_sub}}) &
                                            {BW{active[b]}};

            if (b == 0) begin : gen_cin_low
                assign cin[b] = active[b] & (ctrl.is_sub | (ctrl.use_carry & carry[b]));
            end else begin : gen_cin_chain
                assign cin[b] = ctrl.merge[b-1] ? cout[b-1] :
                                active[b] & (ctrl.is_sub | (ctrl.use_carry & carry[b]));
            end

            vadd_byte_adder adder_inst (
                .a         (srca_gated[b*BW +: BW]),
                .b         (srcb_adder[b*BW +: BW]),
                .cin       (cin[b]),
                .sum       (sum[b*BW +: BW]),
                .prev_cout (prev_cout[b]),
                .cout      (cout[b])
            );

            assign zf_byte[b]     = (sum[b*BW +: BW] == '0);
            assign signed_of[b]   = (cout[b] ^ prev_cout[b]) & ctrl.is_signed;
            // Borrow on subtract, carry on add
            assign unsigned_of[b] = (cout[b] ^ ctrl.is_sub) & ~ctrl.is_signed;
            assign less_byte[b]   = ((sum[b*BW + BW - 1] ^ signed_of[b]) & ctrl.is_signed) |
                                    unsigned_of[b];
        end

        for (genvar s = 0; s < NS; s++) begin : gen_size
            localparam int EB = 2 ** s;
            localparam int NE = NB / EB;

            always_comb begin
                min_max_size[s] = '0;
                zf_size[s]      = '0;
                eq_size[s]      = '0;
                ne_size[s]      = '0;
                lt_size[s]      = '0;
                gt_size[s]      = '0;
                if (ctrl.osize_vector[s]) begin
                    for (int e = 0; e < NE; e++) begin
                        // Less and zero come from the element's top byte and full span
                        if ((ctrl.is_max ^ less_byte[e*EB + EB - 1]) | ~active[e*EB]) begin
                            min_max_size[s][e*EB*BW +: EB*BW] = srca_gated[e*EB*BW +: EB*BW];
                        end else begin
                            min_max_size[s][e*EB*BW +: EB*BW] = srcb_gated[e*EB*BW +: EB*BW];
                        end
                        zf_size[s][e*EB + EB - 1] = &zf_byte[e*EB +: EB];
                        eq_size[s][e] = (&zf_byte[e*EB +: EB]) & active[e*EB];
                        ne_size[s][e] = ~(&zf_byte[e*EB +: EB]) & active[e*EB];
                        lt_size[s][e] = less_byte[e*EB + EB - 1] & active[e*EB];
                        gt_size[s][e] = ~(lt_size[s][e] | eq_size[s][e]) & active[e*EB];
                    end
                end
            end
        end
    endgenerate

    always_comb begin
        min_max_qual = '0;
        zf_all       = '0;
        eq_mask      = '0;
        ne_mask      = '0;
        lt_mask      = '0;
        gt_mask      = '0;
        for (int s = 0; s < NS; s++) begin
            min_max_qual |= min_max_size[s];
            zf_all       |= zf_size[s];
            eq_mask      |= eq_size[s];
            ne_mask      |= ne_size[s];
            lt_mask      |= lt_size[s];
            gt_mask      |= gt_size[s];
        end
        min_max_qual &= {DW{ctrl.is_min_max}};
    end

    assign cmp_mask = (eq_mask & {NB{ctrl.is_set_equal}})
                    | (ne_mask & {NB{ctrl.is_set_nequal}})
                    | (lt_mask & {NB{ctrl.is_set_less}})
                    | (gt_mask & {NB{ctrl.is_set_greater}});

    assign arith_qual = sum & {DW{ctrl.is_arithmetic}};

    // Mask bits land at the bottom of the word
    assign res.data = arith_qual | min_max_qual | {{(DW - NB){1'b0}}, cmp_mask};
    assign res.zf   = zf_all;
    assign res.of   = signed_of | unsigned_of;
    assign res.cf   = cout;

endmodule

/* rtl/vadd_writeback.sv */
/*
 * Writeback register for result and flags
 */
`timescale 1ns/1ps

module vadd_writeback (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   valid,
    input  vadd_pkg::vadd_result_t res_in,
    output logic                   out_valid,
    output vadd_pkg::vadd_result_t res
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid;
        end
    end

    // Holds the last result between operations
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res <= '0;
        end else if (valid) begin
            res <= res_in;
        end
    end

endmodule

/* rtl/vadd_top.sv */
/*
 * Vector add/compare unit top level
 * decode, issue register, datapath, writeback
 */
`timescale 1ns/1ps

module vadd_top (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                in_valid,
    input  vadd_pkg::vadd_op_e                  op,
    input  vadd_pkg::vadd_sew_e                 sew,
    input  vadd_pkg::vadd_operand_t             srca,
    input  vadd_pkg::vadd_operand_t             srcb,
    input  logic [vadd_pkg::VADD_NUM_BYTES-1:0] carry_in,
    output logic                                out_valid,
    output vadd_pkg::vadd_result_t              res
);

    vadd_pkg::vadd_ctrl_t                dec_ctrl;
    vadd_pkg::vadd_ctrl_t                iss_ctrl;
    vadd_pkg::vadd_operand_t             iss_srca;
    vadd_pkg::vadd_operand_t             iss_srcb;
    logic [vadd_pkg::VADD_NUM_BYTES-1:0] iss_carry;
    logic                                iss_valid;
    vadd_pkg::vadd_result_t              alu_res;

    vadd_decode decode_inst (
        .op   (op),
        .sew  (sew),
        .ctrl (dec_ctrl)
    );

    vadd_issue_reg issue_reg_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .ctrl_in   (dec_ctrl),
        .srca_in   (srca),
        .srcb_in   (srcb),
        .carry_in  (carry_in),
        .iss_valid (iss_valid),
        .ctrl      (iss_ctrl),
        .srca      (iss_srca),
        .srcb      (iss_srcb),
        .carry     (iss_carry)
    );

    vadd_alu alu_inst (
        .valid (iss_valid),
        .ctrl  (iss_ctrl),
        .srca  (iss_srca),
        .srcb  (iss_srcb),
        .carry (iss_carry),
        .res   (alu_res)
    );

    vadd_writeback writeback_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid     (iss_valid),
        .res_in    (alu_res),
        .out_valid (out_valid),
        .res       (res)
    );

endmodule

/* testbench/vadd_checker.sv */
/*
 * Bound concurrent assertions on vadd_top output timing
 * and compare mask shape
 */
`timescale 1ns/1ps

module vadd_checker (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   in_valid,
    input logic                   out_valid,
    input vadd_pkg::vadd_op_e     op,
    input vadd_pkg::vadd_sew_e    sew,
    input vadd_pkg::vadd_result_t res
);

    logic cmp_op;
    int   fail_count = 0;

    assign cmp_op = (op == vadd_pkg::SEQ)  || (op == vadd_pkg::SNE)  ||
                    (op == vadd_pkg::SLT)  || (op == vadd_pkg::SLTU) ||
                    (op == vadd_pkg::SGT)  || (op == vadd_pkg::SGTU);

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else begin
            $error("out_valid high while reset is asserted");
            fail_count++;
        end

    // Two register stages between input and output
    latency_two: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else begin
            $error("out_valid does not follow in_valid by two cycles");
            fail_count++;
        end

    // One mask bit per element and nothing above
    mask_shape: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && $past(cmp_op, 2)) |->
        ((res.data >> (vadd_pkg::VADD_NUM_BYTES >> $past(sew, 2))) == '0))
        else begin
            $error("compare result has bits set above the element count");
            fail_count++;
        end

endmodule

bind vadd_top vadd_checker checker_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .op        (op),
    .sew       (sew),
    .res       (res)
);

/* testbench/tb_vadd_top.sv */
/*
 * Testbench for vadd_top with a directed table, LCG random operations,
 * reference model, result queue and watchdog
 */
`timescale 1ns/1ps

module tb_vadd_top;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_TABLE       = 22;
    localparam int NUM_RANDOM      = 200;
    localparam int WATCHDOG_CYCLES = NUM_TABLE + NUM_RANDOM + 20;
    localparam logic [31:0] SEED   = 32'd95088;

    // Directed operand pairs
    localparam logic [63:0] A0 = 64'h0102_0304_FF80_7F01, B0 = 64'h0101_0101_0180_0101;
    localparam logic [63:0] A1 = 64'h0000_0000_0000_0510, B1 = 64'h0000_0000_0000_0601;
    localparam logic [63:0] A2 = 64'h0000_0000_0001_0000, B2 = 64'h0000_0000_0000_0001;
    localparam logic [63:0] A3 = 64'h0001_0002_0003_FFFF, B3 = 64'h0001_0001_0001_0000;
    localparam logic [63:0] A4 = 64'h0000_0000_05FF_7F80, B4 = 64'h0000_0000_0501_8001;
    localparam logic [63:0] A5 = 64'h8000_0000_0000_0005, B5 = 64'h0000_0001_0000_0007;
    localparam logic [63:0] A6 = 64'h8000_0005_0003_0007, B6 = 64'h0001_0005_0004_0002;

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    in_valid;
    vadd_pkg::vadd_op_e      op;
    vadd_pkg::vadd_sew_e     sew;
    vadd_pkg::vadd_operand_t srca;
    vadd_pkg::vadd_operand_t srcb;
    logic [7:0]              carry_in;
    logic                    out_valid;
    vadd_pkg::vadd_result_t  res;

    vadd_pkg::vadd_op_e  t_op    [NUM_TABLE];
    vadd_pkg::vadd_sew_e t_sew   [NUM_TABLE];
    logic [63:0]         t_a     [NUM_TABLE];
    logic [63:0]         t_b     [NUM_TABLE];
    logic [7:0]          t_mask  [NUM_TABLE];
    logic [7:0]          t_carry [NUM_TABLE];
    logic [63:0]         t_exp   [NUM_TABLE];
    int                  n_table = 0;

    vadd_pkg::vadd_result_t exp_q [$];
    int                     issue_q [$];
    vadd_pkg::vadd_result_t exp_res;
    int                     issue_cycle;
    int                     cycle = 0;
    int                     errors = 0;
    int                     n_checked = 0;
    logic [31:0]            lcg_state;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    vadd_top vadd_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .sew       (sew),
        .srca      (srca),
        .srcb      (srcb),
        .carry_in  (carry_in),
        .out_valid (out_valid),
        .res       (res)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Element mask to byte mask
    function automatic logic [7:0] expand_mask(input logic [7:0] m, input vadd_pkg::vadd_sew_e w);
        logic [7:0] v;
        for (int b = 0; b < 8; b++) begin
            v[b] = m[b >> w];
        end
        return v;
    endfunction

    function automatic vadd_pkg::vadd_result_t ref_model(
        input vadd_pkg::vadd_op_e o, input vadd_pkg::vadd_sew_e w,
        input logic [63:0] a, input logic [63:0] b,
        input logic [7:0] bv, input logic [7:0] cbits
    );
        vadd_pkg::vadd_result_t r;
        logic [63:0] sum, ae, be, se, wmask;
        logic [8:0]  t;
        logic [7:0]  ab, bb;
        logic        is_sub, is_sgn, carry, act, less, eq;
        int          eb, lo, bits;
        r      = '0;
        sum    = '0;
        is_sub = !(o == vadd_pkg::ADD || o == vadd_pkg::ADC);
        is_sgn = (o == vadd_pkg::MIN) || (o == vadd_pkg::MAX) ||
                 (o == vadd_pkg::SLT) || (o == vadd_pkg::SGT);
        eb     = 1 << w;
        bits   = 8 * eb;
        wmask  = (bits == 64) ? '1 : ((64'd1 << bits) - 1);
        for (int e = 0; e < 8 / eb; e++) begin
            lo    = e * eb;
            act   = bv[lo];
            carry = act & (is_sub | ((o == vadd_pkg::ADC) & cbits[lo]));
            // Byte ripple within the element only
            for (int k = lo; k < lo + eb; k++) begin
                ab   = a[8*k +: 8];
                bb   = act ? (b[8*k +: 8] ^ {8{is_sub}}) : 8'h00;
                t    = ab + bb + carry;
                sum[8*k +: 8] = t[7:0];
                r.cf[k] = t[8];
                // Like-signed inputs giving a result of the other sign
                r.of[k] = is_sgn ? ((ab[7] == bb[7]) && (t[7] != ab[7])) : (t[8] ^ is_sub);
                carry   = t[8];
            end
            ae = (a >> (8 * lo)) & wmask;
            be = (b >> (8 * lo)) & wmask;
            se = (sum >> (8 * lo)) & wmask;
            r.zf[lo + eb - 1] = (se == 0);
            eq   = (ae == be);
            less = is_sgn ? ($signed(ae << (64 - bits)) < $signed(be << (64 - bits))) : (ae < be);
            case (o)
                vadd_pkg::MIN, vadd_pkg::MINU: r.data |= ((act && !less) ? be : ae) << (8 * lo);
                vadd_pkg::MAX, vadd_pkg::MAXU: r.data |= ((act && less) ? be : ae) << (8 * lo);
                vadd_pkg::SEQ: r.data[e] = act & eq;
                vadd_pkg::SNE: r.data[e] = act & !eq;
                vadd_pkg::SLT, vadd_pkg::SLTU: r.data[e] = act & less;
                vadd_pkg::SGT, vadd_pkg::SGTU: r.data[e] = act & !less & !eq;
                default: r.data = sum;
            endcase
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic add_entry(input vadd_pkg::vadd_op_e o, input vadd_pkg::vadd_sew_e w,
                             input logic [63:0] a, input logic [63:0] b,
                             input logic [7:0] m, input logic [7:0] c, input logic [63:0] x);
        t_op[n_table]    = o;
        t_sew[n_table]   = w;
        t_a[n_table]     = a;
        t_b[n_table]     = b;
        t_mask[n_table]  = m;
        t_carry[n_table] = c;
        t_exp[n_table]   = x;
        n_table++;
    endtask

    task automatic fill_table();
        add_entry(vadd_pkg::ADD,  vadd_pkg::SEW8,  A0, B0, 8'hFF, 8'h00, 64'h0203_0405_0000_8002);
        add_entry(vadd_pkg::ADD,  vadd_pkg::SEW16, A0, B0, 8'hFF, 8'h00, 64'h0203_0405_0100_8002);
        add_entry(vadd_pkg::ADD,  vadd_pkg::SEW32, A0, B0, 8'hFF, 8'h00, 64'h0203_0405_0100_8002);
        add_entry(vadd_pkg::ADD,  vadd_pkg::SEW64, A0, B0, 8'hFF, 8'h00, 64'h0203_0406_0100_8002);
        add_entry(vadd_pkg::SUB,  vadd_pkg::SEW8,  A1, B1, 8'hFF, 8'h00, 64'h0000_0000_0000_FF0F);
        add_entry(vadd_pkg::SUB,  vadd_pkg::SEW16, A2, B2, 8'hFF, 8'h00, 64'h0000_0000_0001_FFFF);
        add_entry(vadd_pkg::SUB,  vadd_pkg::SEW32, A2, B2, 8'hFF, 8'h00, 64'h0000_0000_0000_FFFF);
        add_entry(vadd_pkg::SUB,  vadd_pkg::SEW64, A2, B2, 8'h00, 8'h00, A2);
        // Carry bit 1 sits inside element 0 and is ignored
        add_entry(vadd_pkg::ADC,  vadd_pkg::SEW16, A3, B3, 8'hFF, 8'h13, 64'h0002_0004_0004_0000);
        add_entry(vadd_pkg::MIN,  vadd_pkg::SEW8,  A4, B4, 8'hFF, 8'h00, 64'h0000_0000_05FF_8080);
        add_entry(vadd_pkg::MINU, vadd_pkg::SEW8,  A4, B4, 8'hFF, 8'h00, 64'h0000_0000_0501_7F01);
        add_entry(vadd_pkg::MAX,  vadd_pkg::SEW8,  A4, B4, 8'hFF, 8'h00, 64'h0000_0000_0501_7F01);
        add_entry(vadd_pkg::MAXU, vadd_pkg::SEW8,  A4, B4, 8'hFF, 8'h00, 64'h0000_0000_05FF_8080);
        add_entry(vadd_pkg::MAX,  vadd_pkg::SEW32, A5, B5, 8'h01, 8'h00, 64'h8000_0000_0000_0007);
        add_entry(vadd_pkg::SEQ,  vadd_pkg::SEW16, A6, B6, 8'hFF, 8'h00, 64'h4);
        add_entry(vadd_pkg::SNE,  vadd_pkg::SEW16, A6, B6, 8'hFF, 8'h00, 64'hB);
        add_entry(vadd_pkg::SLT,  vadd_pkg::SEW16, A6, B6, 8'hFF, 8'h00, 64'hA);
        add_entry(vadd_pkg::SLTU, vadd_pkg::SEW16, A6, B6, 8'hFF, 8'h00, 64'h2);
        add_entry(vadd_pkg::SGT,  vadd_pkg::SEW16, A6, B6, 8'hFF, 8'h00, 64'h1);
        add_entry(vadd_pkg::SGTU, vadd_pkg::SEW16, A6, B6, 8'hFF, 8'h00, 64'h9);
        add_entry(vadd_pkg::SEQ,  vadd_pkg::SEW8,  A0, A0, 8'h0F, 8'h00, 64'hF);
        add_entry(vadd_pkg::SLT,  vadd_pkg::SEW64, A6, B6, 8'h00, 8'h00, 64'h0);
    endtask

    // Drive one operation and queue its expected result
    task automatic apply_op(input vadd_pkg::vadd_op_e o, input vadd_pkg::vadd_sew_e w,
                            input logic [63:0] a, input logic [63:0] b, input logic [7:0] m,
                            input logic [7:0] c, input logic use_exp, input logic [63:0] x);
        vadd_pkg::vadd_result_t r;
        @(posedge clk);
        #2;
        in_valid   = 1'b1;
        op         = o;
        sew        = w;
        srca.data  = a;
        srca.valid = expand_mask(m, w);
        srcb.data  = b;
        srcb.valid = expand_mask(m, w);
        carry_in   = c;
        r = ref_model(o, w, a, b, expand_mask(m, w), c);
        if (use_exp) begin
            r.data = x;
        end
        exp_q.push_back(r);
        issue_q.push_back(cycle);
    endtask

    task automatic run_random();
        logic [31:0] s0, s1, s2, s3, s4, s5;
        logic [63:0] b;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            s0 = lcg_step(lcg_state);
            s1 = lcg_step(s0);
            s2 = lcg_step(s1);
            s3 = lcg_step(s2);
            s4 = lcg_step(s3);
            s5 = lcg_step(s4);
            lcg_state = s5;
            // Occasional equal operands for the compares
            b = (s0[27:24] == 4'h0) ? {s1, s2} : {s3, s4};
            apply_op(vadd_pkg::vadd_op_e'(s0[31:28] % 13), vadd_pkg::vadd_sew_e'(s0[23:22]),
                     {s1, s2}, b, s5[31:24], s5[23:16], 1'b0, 64'h0);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t: out_valid high with no operation pending", $time);
            end else begin
                exp_res     = exp_q.pop_front();
                issue_cycle = issue_q.pop_front();
                check("res.data", exp_res.data, res.data);
                check("res.zf", exp_res.zf, res.zf);
                check("res.of", exp_res.of, res.of);
                check("res.cf", exp_res.cf, res.cf);
                check("latency", 64'd2, cycle - issue_cycle);
                n_checked++;
            end
        end
    end

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        op        = vadd_pkg::ADD;
        sew       = vadd_pkg::SEW8;
        srca      = '0;
        srcb      = '0;
        carry_in  = '0;
        lcg_state = SEED;
        fill_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        check("out_valid", 64'd0, out_valid);
        @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (int i = 0; i < n_table; i++) begin
            apply_op(t_op[i], t_sew[i], t_a[i], t_b[i], t_mask[i], t_carry[i], 1'b1, t_exp[i]);
        end
        run_random();
        @(posedge clk);
        #2;
        in_valid = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);

        $display("Checked %0d operations, errors: %0d, assertion failures: %0d",
                 n_checked, errors, vadd_top_inst.checker_inst.fail_count);
        if (errors == 0 && vadd_top_inst.checker_inst.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: results still pending after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* src.f */
rtl/vadd_pkg.sv
rtl/vadd_decode.sv
rtl/vadd_issue_reg.sv
rtl/vadd_byte_adder.sv
rtl/vadd_alu.sv
rtl/vadd_writeback.sv
rtl/vadd_top.sv
testbench/vadd_checker.sv
testbench/tb_vadd_top.sv
